/* tests/rs_stimulus.txt */
# D cat op dest a_rdy a_tag a_val b_rdy b_tag b_val expected gap (hex fields, gap -1 = random)
# F cat expected_full | S squash | W idle_cycles
D 0 0 01 1 00 00000005 1 00 00000007 0000000c -1
D 0 1 02 1 00 00000003 1 00 00000005 fffffffe -1
D 0 2 03 1 00 f0f0f0f0 1 00 ff00ff00 f000f000 -1
D 0 3 04 1 00 f0f0f0f0 1 00 0f0f0f0f ffffffff -1
D 0 4 05 1 00 12345678 1 00 ffffffff edcba987 -1
D 0 5 06 1 00 00000001 1 00 00000024 00000010 -1
D 0 6 07 1 00 80000000 1 00 0000001f 00000001 -1
D 0 7 08 1 00 fffffffe 1 00 00000001 00000001 -1
D 1 0 09 1 00 00010000 1 00 00010000 00000000 -1
D 1 1 0a 1 00 00010000 1 00 00010000 00000001 -1
W 10
D 1 0 0b 1 00 00000003 1 00 00000007 00000015 -1
D 0 0 0c 0 0b 00000000 1 00 00000001 00000016 0
D 0 3 0d 0 0c 00000000 0 0b 00000000 00000017 0
W 10
D 0 0 0e 1 00 00000010 1 00 00000020 00000030 -1
D 0 1 0f 0 0e 00000000 1 00 00000008 00000028 1
W 10
D 1 0 10 0 1f 00000000 1 00 00000002 00000000 0
D 1 0 11 0 1f 00000000 1 00 00000003 00000000 0
F 1 1
F 0 0
D 1 0 12 1 00 00000002 1 00 00000002 00000004 0
S
F 1 0
F 0 0
D 1 1 13 1 00 ffffffff 1 00 ffffffff fffffffe -1
D 0 0 14 1 00 00000001 1 00 00000001 00000002 -1

/* rs_station.f */
hw/rs_pkg.sv
hw/rs_slot.sv
hw/fu_alu.sv
hw/fu_mult.sv
hw/rs_alloc.sv
hw/cdb_arbiter.sv
hw/rs_top.sv
tests/rs_tb.sv

/* Makefile */
SOURCES := $(wildcard hw/*.sv) $(wildcard tests/*.sv)

.PHONY: run clean

run: obj_dir/Vrs_tb
	@out="$$(./obj_dir/Vrs_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

obj_dir/Vrs_tb: rs_station.f $(SOURCES)
	verilator --binary --timing --top-module rs_tb -f rs_station.f

clean:
	rm -rf obj_dir

/* tests/rs_tb.sv */
`default_nettype none

module rs_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 20;
    localparam int NUM_TAGS    = 2 ** rs_pkg::TAG_W;

    logic              clock;
    logic              reset;
    logic              squash;
    rs_pkg::dispatch_t dispatch;
    logic              full;
    rs_pkg::cdb_t      cdb;

    // scoreboard, indexed by tag
    logic                    pending   [NUM_TAGS];
    rs_pkg::fu_cat_t         pend_cat  [NUM_TAGS];
    logic [rs_pkg::XLEN-1:0] expected  [NUM_TAGS];
    int                      disp_edge [NUM_TAGS];
    int                      min_lat   [NUM_TAGS];
    string                   test_name [NUM_TAGS];

    int          cycle;
    int          errors;
    int          line_count;
    logic [31:0] lcg_state;

    rs_top uut (
        .clock    (clock),
        .reset    (reset),
        .squash   (squash),
        .dispatch (dispatch),
        .full     (full),
        .cdb      (cdb)
    );

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic string op_name(input int cat, input int op);
        string alu_names [8];
        alu_names = '{"add", "sub", "and", "or", "xor", "sll", "srl", "slt"};
        if (cat == 1) begin
            return (op == 1) ? "mul_hi" : "mul_lo";
        end
        return alu_names[op & 7];
    endfunction

    // tags still owed a broadcast in one category
    function automatic int pending_count(input rs_pkg::fu_cat_t cat);
        int count;
        count = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (pending[t] && pend_cat[t] == cat) begin
                count++;
            end
        end
        return count;
    endfunction

    ////////////////////////////////////////
    // bus monitor
    ////////////////////////////////////////

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (!reset && cdb.valid) begin
            assert (pending[cdb.tag]) else begin
                errors++;
                $display("bus carried tag %02h, which is unknown or already retired",
                         cdb.tag);
            end
            if (pending[cdb.tag]) begin
                assert (cdb.value == expected[cdb.tag]) else begin
                    errors++;
                    $display("ERROR %s: expected %08h actual %08h",
                             test_name[cdb.tag], expected[cdb.tag], cdb.value);
                end
                assert (cycle - disp_edge[cdb.tag] >= min_lat[cdb.tag]) else begin
                    errors++;
                    $display("%s finished after %0d cycles, sooner than allowed",
                             test_name[cdb.tag], cycle - disp_edge[cdb.tag]);
                end
                pending[cdb.tag] = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // driver tasks
    ////////////////////////////////////////

    task automatic idle_cycle();
        @(negedge clock);
        dispatch.valid = 1'b0;
        @(posedge clock);
    endtask

    task automatic send_instr(input rs_pkg::dispatch_t pkt, input logic [31:0] exp_value,
                              input int gap);
        int   idle;
        int   slots;
        logic exp_full;
        idle = gap;
        if (gap < 0) begin
            lcg_state = lcg_next(lcg_state);
            idle = int'(lcg_state[17:16]);
        end
        repeat (idle) idle_cycle();
        @(negedge clock);
        // each instruction not yet broadcast holds one slot
        slots    = (pkt.cat == rs_pkg::CAT_MULT) ? rs_pkg::NUM_MULT : rs_pkg::NUM_ALU;
        exp_full = pending_count(pkt.cat) >= slots;
        dispatch = pkt;
        @(posedge clock);
        assert (full == exp_full) else begin
            errors++;
            $display("ERROR full at %s tag %02h: expected %0d actual %0d",
                     op_name(int'(pkt.cat), int'(pkt.op)), pkt.dest_tag, exp_full, full);
        end
        // a dispatch while full is dropped
        if (!exp_full) begin
            pending[pkt.dest_tag]   = 1'b1;
            pend_cat[pkt.dest_tag]  = pkt.cat;
            expected[pkt.dest_tag]  = exp_value;
            disp_edge[pkt.dest_tag] = cycle;
            min_lat[pkt.dest_tag]   = (pkt.cat == rs_pkg::CAT_MULT) ?
                                      rs_pkg::MULT_STAGES + 1 : 2;
            test_name[pkt.dest_tag] = $sformatf("%s tag %02h",
                                                op_name(int'(pkt.cat), int'(pkt.op)),
                                                pkt.dest_tag);
        end
    endtask

    task automatic check_full(input int cat, input int exp_full);
        @(negedge clock);
        dispatch       = '0;
        dispatch.cat   = rs_pkg::fu_cat_t'(cat);
        @(posedge clock);
        assert (full == exp_full[0]) else begin
            errors++;
            $display("ERROR full check cat %0d: expected %0d actual %0d", cat, exp_full, full);
        end
    endtask

    task automatic apply_squash();
        rs_pkg::dispatch_t probe;
        probe             = '0;
        probe.valid       = 1'b1;
        probe.cat         = rs_pkg::CAT_ALU;
        probe.op          = rs_pkg::ALU_ADD;
        probe.dest_tag    = '1;
        probe.src_a.ready = 1'b1;
        probe.src_b.ready = 1'b1;
        @(negedge clock);
        // ready alu op alongside squash, must be dropped
        dispatch = probe;
        squash   = 1'b1;
        @(posedge clock);
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t] = 1'b0;
        end
        @(negedge clock);
        dispatch.valid = 1'b0;
        squash         = 1'b0;
        // bus stays quiet with nothing dispatched
        repeat (4) begin
            @(posedge clock);
            assert (!cdb.valid) else begin
                errors++;
                $display("bus went valid after squash with no dispatch");
            end
        end
    endtask

    ////////////////////////////////////////
    // stimulus playback
    ////////////////////////////////////////

    initial begin
        int                fd;
        int                n;
        int                cat;
        int                op;
        int                a_rdy;
        int                b_rdy;
        int                gap;
        int                count;
        int                wait_cycles;
        logic [31:0]       dest;
        logic [31:0]       a_tag;
        logic [31:0]       a_val;
        logic [31:0]       b_tag;
        logic [31:0]       b_val;
        logic [31:0]       exp_value;
        logic [63:0]       kind;
        logic [8*256-1:0]  rest;
        rs_pkg::dispatch_t pkt;
        reset      = 1'b1;
        squash     = 1'b0;
        dispatch   = '0;
        cycle      = 0;
        errors     = 0;
        line_count = 0;
        lcg_state  = 32'h8c3c_b95f;
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t]   = 1'b0;
            pend_cat[t]  = rs_pkg::CAT_ALU;
            expected[t]  = '0;
            disp_edge[t] = 0;
            min_lat[t]   = 0;
        end
        fd = $fopen("tests/rs_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            $display("test failed");
            $finish;
        end else begin
            count = 0;
            while ($fgets(rest, fd) != 0) begin
                count++;
            end
            $fclose(fd);
            line_count = count;
            fd = $fopen("tests/rs_stimulus.txt", "r");
            repeat (8) @(posedge clock);
            @(negedge clock);
            reset = 1'b0;
            while (!$feof(fd)) begin
                n = $fscanf(fd, " %s", kind);
                if (n != 1) begin
                    break;
                end
                if (kind == "#") begin
                    n = $fgets(rest, fd);
                end else if (kind == "D") begin
                    n = $fscanf(fd, "%d %d %h %d %h %h %d %h %h %h %d",
                                cat, op, dest, a_rdy, a_tag, a_val,
                                b_rdy, b_tag, b_val, exp_value, gap);
                    pkt             = '0;
                    pkt.valid       = 1'b1;
                    pkt.cat         = rs_pkg::fu_cat_t'(cat);
                    pkt.op          = rs_pkg::OP_W'(op);
                    pkt.dest_tag    = rs_pkg::TAG_W'(dest);
                    pkt.src_a.ready = a_rdy[0];
                    pkt.src_a.tag   = rs_pkg::TAG_W'(a_tag);
                    pkt.src_a.value = a_val;
                    pkt.src_b.ready = b_rdy[0];
                    pkt.src_b.tag   = rs_pkg::TAG_W'(b_tag);
                    pkt.src_b.value = b_val;
                    send_instr(pkt, exp_value, gap);
                end else if (kind == "F") begin
                    n = $fscanf(fd, "%d %d", cat, op);
                    check_full(cat, op);
                end else if (kind == "S") begin
                    apply_squash();
                end else if (kind == "W") begin
                    n = $fscanf(fd, "%d", gap);
                    repeat (gap) idle_cycle();
                end
            end
            $fclose(fd);
            idle_cycle();
            // let the last results drain
            wait_cycles = 0;
            while (pending_count(rs_pkg::CAT_ALU) + pending_count(rs_pkg::CAT_MULT) != 0
                   && wait_cycles < 100) begin
                @(posedge clock);
                wait_cycles++;
            end
            for (int t = 0; t < NUM_TAGS; t++) begin
                assert (!pending[t]) else begin
                    errors++;
                    $display("tag %02h never appeared on the bus", t);
                end
            end
            $display("errors: %0d", errors);
            if (errors == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

    // watchdog, scaled by stimulus length
    initial begin
        wait (line_count != 0);
        repeat (line_count * 30) @(posedge clock);
        $display("run exceeded its time limit");
        $display("errors: %0d", errors);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/rs_top.sv */
`default_nettype none

module rs_top (
    input  logic              clock,
    input  logic              reset,
    input  logic              squash,
    input  rs_pkg::dispatch_t dispatch,
    output logic              full,
    output rs_pkg::cdb_t      cdb
);

    logic [rs_pkg::NUM_SLOTS-1:0] busy;
    logic [rs_pkg::NUM_SLOTS-1:0] write;
    logic [rs_pkg::NUM_SLOTS-1:0] grant;
    logic [rs_pkg::TAG_W-1:0]     dest_tags [rs_pkg::NUM_SLOTS];
    rs_pkg::fu_result_t           results   [rs_pkg::NUM_SLOTS];

    rs_alloc u_alloc (
        .squash   (squash),
        .dispatch (dispatch),
        .busy     (busy),
        .write    (write),
        .full     (full)
    );

    ////////////////////////////////////////
    // alu slots and units
    ////////////////////////////////////////

    for (genvar i = 0; i < rs_pkg::NUM_ALU; i++) begin : g_alu
        logic               issue_valid;
        rs_pkg::alu_issue_t issue;

        rs_slot #(.issue_t(rs_pkg::alu_issue_t)) u_slot (
            .clock       (clock),
            .reset       (reset),
            .squash      (squash),
            .write       (write[i]),
            .dispatch    (dispatch),
            .cdb         (cdb),
            .grant       (grant[i]),
            .busy        (busy[i]),
            .issue_valid (issue_valid),
            .issue       (issue),
            .dest_tag    (dest_tags[i])
        );

        fu_alu u_fu (
            .clock       (clock),
            .reset       (reset),
            .squash      (squash),
            .issue_valid (issue_valid),
            .issue       (issue),
            .grant       (grant[i]),
            .result      (results[i])
        );
    end

    ////////////////////////////////////////
    // multiply slots and units
    ////////////////////////////////////////

    for (genvar j = 0; j < rs_pkg::NUM_MULT; j++) begin : g_mult
        localparam int S = rs_pkg::NUM_ALU + j;

        logic                issue_valid;
        rs_pkg::mult_issue_t issue;

        rs_slot #(.issue_t(rs_pkg::mult_issue_t)) u_slot (
            .clock       (clock),
            .reset       (reset),
            .squash      (squash),
            .write       (write[S]),
            .dispatch    (dispatch),
            .cdb         (cdb),
            .grant       (grant[S]),
            .busy        (busy[S]),
            .issue_valid (issue_valid),
            .issue       (issue),
            .dest_tag    (dest_tags[S])
        );

        fu_mult u_fu (
            .clock       (clock),
            .reset       (reset),
            .squash      (squash),
            .issue_valid (issue_valid),
            .issue       (issue),
            .grant       (grant[S]),
            .result      (results[S])
        );
    end

    cdb_arbiter u_arbiter (
        .clock     (clock),
        .reset     (reset),
        .squash    (squash),
        .results   (results),
        .dest_tags (dest_tags),
        .grant     (grant),
        .cdb       (cdb)
    );

endmodule

`default_nettype wire

/* hw/cdb_arbiter.sv */
`default_nettype none

module cdb_arbiter (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         squash,
    input  rs_pkg::fu_result_t           results   [rs_pkg::NUM_SLOTS],
    input  logic [rs_pkg::TAG_W-1:0]     dest_tags [rs_pkg::NUM_SLOTS],
    output logic [rs_pkg::NUM_SLOTS-1:0] grant,
    output rs_pkg::cdb_t                 cdb
);

    logic [rs_pkg::SLOT_IDX_W-1:0] pointer;
    logic [rs_pkg::SLOT_IDX_W-1:0] sel;
    logic                          found;

    // first finished unit at or after the pointer
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = '0;
        for (int k = 0; k < rs_pkg::NUM_SLOTS; k++) begin
            idx = int'(pointer) + k;
            if (idx >= rs_pkg::NUM_SLOTS) begin
                idx = idx - rs_pkg::NUM_SLOTS;
            end
            if (!found && results[idx].valid) begin
                found = 1'b1;
                sel   = rs_pkg::SLOT_IDX_W'(idx);
            end
        end
    end

    assign grant = {{(rs_pkg::NUM_SLOTS-1){1'b0}}, found} << sel;

    assign cdb.valid = found;
    assign cdb.tag   = dest_tags[sel];
    assign cdb.value = results[sel].value;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            pointer <= '0;
        end else if (found) begin
            // one past the winner
            if (int'(sel) == rs_pkg::NUM_SLOTS - 1) begin
                pointer <= '0;
            end else begin
                pointer <= sel + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rs_alloc.sv */
`default_nettype none

module rs_alloc (
    input  logic                         squash,
    input  rs_pkg::dispatch_t            dispatch,
    input  logic [rs_pkg::NUM_SLOTS-1:0] busy,
    output logic [rs_pkg::NUM_SLOTS-1:0] write,
    output logic                         full
);

    logic [rs_pkg::NUM_SLOTS-1:0] cat_mask;
    logic [rs_pkg::NUM_SLOTS-1:0] idle;
    logic [rs_pkg::NUM_SLOTS-1:0] pick;

    // slot range of the requested category
    always_comb begin
        if (dispatch.cat == rs_pkg::CAT_MULT) begin
            cat_mask = {{rs_pkg::NUM_MULT{1'b1}}, {rs_pkg::NUM_ALU{1'b0}}};
        end else begin
            cat_mask = {{rs_pkg::NUM_MULT{1'b0}}, {rs_pkg::NUM_ALU{1'b1}}};
        end
    end

    assign idle = cat_mask & ~busy;

    // lowest idle slot wins
    always_comb begin
        logic found;
        found = 1'b0;
        pick  = '0;
        for (int i = 0; i < rs_pkg::NUM_SLOTS; i++) begin
            if (idle[i] && !found) begin
                pick[i] = 1'b1;
                found   = 1'b1;
            end
        end
    end

    assign full = ~|idle;

    // no idle slot means pick is empty, so a dispatch while full is dropped
    assign write = (dispatch.valid && !squash) ? pick : '0;

endmodule

`default_nettype wire

/* hw/fu_mult.sv */
`default_nettype none

module fu_mult (
    input  logic                clock,
    input  logic                reset,
    input  logic                squash,
    input  logic                issue_valid,
    input  rs_pkg::mult_issue_t issue,
    input  logic                grant,
    output rs_pkg::fu_result_t  result
);

    localparam int LAST = rs_pkg::MULT_STAGES - 1;

    logic [LAST:0]             stage_valid;
    rs_pkg::mult_issue_t       operands;
    rs_pkg::mult_op_t          op_q      [1:LAST-1];
    logic [rs_pkg::PROD_W-1:0] product_q [1:LAST-1];
    logic [rs_pkg::XLEN-1:0]   value_q;

    ////////////////////////////////////////
    // stage valids
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= issue_valid;
            for (int s = 1; s < LAST; s++) begin
                stage_valid[s] <= stage_valid[s-1];
            end
            // last stage holds until granted
            if (stage_valid[LAST-1]) begin
                stage_valid[LAST] <= 1'b1;
            end else if (grant) begin
                stage_valid[LAST] <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            operands <= issue;
        end
        // unsigned full-width product
        product_q[1] <= {{rs_pkg::XLEN{1'b0}}, operands.a}
                      * {{rs_pkg::XLEN{1'b0}}, operands.b};
        op_q[1]      <= operands.op;
        for (int s = 2; s < LAST; s++) begin
            product_q[s] <= product_q[s-1];
            op_q[s]      <= op_q[s-1];
        end
        if (stage_valid[LAST-1]) begin
            if (op_q[LAST-1] == rs_pkg::MULT_HI) begin
                value_q <= product_q[LAST-1][rs_pkg::PROD_W-1:rs_pkg::XLEN];
            end else begin
                value_q <= product_q[LAST-1][rs_pkg::XLEN-1:0];
            end
        end
    end

    assign result.valid = stage_valid[LAST];
    assign result.value = value_q;

endmodule

`default_nettype wire

/* hw/fu_alu.sv */
`default_nettype none

module fu_alu (
    input  logic               clock,
    input  logic               reset,
    input  logic               squash,
    input  logic               issue_valid,
    input  rs_pkg::alu_issue_t issue,
    input  logic               grant,
    output rs_pkg::fu_result_t result
);

    logic [rs_pkg::XLEN-1:0] alu_value;
    logic [rs_pkg::XLEN-1:0] value_q;
    logic                    valid_q;

    always_comb begin
        case (issue.op)
            rs_pkg::ALU_ADD: alu_value = issue.a + issue.b;
            rs_pkg::ALU_SUB: alu_value = issue.a - issue.b;
            rs_pkg::ALU_AND: alu_value = issue.a & issue.b;
            rs_pkg::ALU_OR:  alu_value = issue.a | issue.b;
            rs_pkg::ALU_XOR: alu_value = issue.a ^ issue.b;
            rs_pkg::ALU_SLL: alu_value = issue.a << issue.b[4:0];
            rs_pkg::ALU_SRL: alu_value = issue.a >> issue.b[4:0];
            rs_pkg::ALU_SLT: alu_value = {{(rs_pkg::XLEN-1){1'b0}},
                                          $signed(issue.a) < $signed(issue.b)};
            default:         alu_value = '0;
        endcase
    end

    // held until the arbiter takes it
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            valid_q <= 1'b0;
        end else if (issue_valid) begin
            valid_q <= 1'b1;
        end else if (grant) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            value_q <= alu_value;
        end
    end

    assign result.valid = valid_q;
    assign result.value = value_q;

endmodule

`default_nettype wire

/* hw/rs_slot.sv */
`default_nettype none

module rs_slot #(
    parameter type issue_t = rs_pkg::alu_issue_t
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     squash,
    input  logic                     write,
    input  rs_pkg::dispatch_t        dispatch,
    input  rs_pkg::cdb_t             cdb,
    input  logic                     grant,
    output logic                     busy,
    output logic                     issue_valid,
    output issue_t                   issue,
    output logic [rs_pkg::TAG_W-1:0] dest_tag
);

    logic                    issued;
    logic [rs_pkg::OP_W-1:0] op_code;
    rs_pkg::operand_t        src_a;
    rs_pkg::operand_t        src_b;

    // picks up a broadcast value for an operand still waiting on its tag
    function automatic rs_pkg::operand_t wakeup(
        input rs_pkg::operand_t src,
        input rs_pkg::cdb_t     bus
    );
        rs_pkg::operand_t captured;
        captured = src;
        if (!src.ready && bus.valid && bus.tag == src.tag) begin
            captured.ready = 1'b1;
            captured.value = bus.value;
        end
        return captured;
    endfunction

    ////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy   <= 1'b0;
            issued <= 1'b0;
        end else if (write) begin
            busy   <= 1'b1;
            issued <= 1'b0;
        end else begin
            if (issue_valid) begin
                issued <= 1'b1;
            end
            // result went out on the bus
            if (grant) begin
                busy <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // operands
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (write) begin
            dest_tag <= dispatch.dest_tag;
            op_code  <= dispatch.op;
            // same-cycle bypass from the bus
            src_a    <= wakeup(dispatch.src_a, cdb);
            src_b    <= wakeup(dispatch.src_b, cdb);
        end else if (busy) begin
            src_a    <= wakeup(src_a, cdb);
            src_b    <= wakeup(src_b, cdb);
        end
    end

    // one cycle only, the first with both operands in hand
    assign issue_valid = busy && src_a.ready && src_b.ready && !issued;

    assign issue = issue_t'({op_code, src_a.value, src_b.value});

endmodule

`default_nettype wire

/* hw/rs_pkg.sv */
`default_nettype none

package rs_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    localparam int XLEN        = 32;
    localparam int TAG_W       = 5;
    localparam int OP_W        = 3;

    localparam int NUM_ALU     = 4;
    localparam int NUM_MULT    = 2;
    // alu slots occupy the low indices
    localparam int NUM_SLOTS   = NUM_ALU + NUM_MULT;
    localparam int SLOT_IDX_W  = $clog2(NUM_SLOTS);

    localparam int MULT_STAGES = 3;
    localparam int PROD_W      = 2 * XLEN;

    ////////////////////////////////////////
    // operation encodings
    ////////////////////////////////////////

    typedef enum logic {
        CAT_ALU,
        CAT_MULT
    } fu_cat_t;

    typedef enum logic [OP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_t;

    // same width as alu_op_t so both issue packets share one layout
    typedef enum logic [OP_W-1:0] {
        MULT_LO,
        MULT_HI
    } mult_op_t;

    ////////////////////////////////////////
    // packets
    ////////////////////////////////////////

    typedef struct packed {
        logic             ready;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } operand_t;

    typedef struct packed {
        logic             valid;
        fu_cat_t          cat;
        logic [OP_W-1:0]  op;
        logic [TAG_W-1:0] dest_tag;
        operand_t         src_a;
        operand_t         src_b;
    } dispatch_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } cdb_t;

    typedef struct packed {
        alu_op_t         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } alu_issue_t;

    typedef struct packed {
        mult_op_t        op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } mult_issue_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] value;
    } fu_result_t;

endpackage

`default_nettype wire
